/* include/riscv_regs.svh */
`ifndef RISCV_REGS_SVH
`define RISCV_REGS_SVH

////////////////////
// architectural register numbers the control logic cares about
////////////////////

// x0 is hard wired to zero and is never a real producer
`define REG_ZERO 5'd0
// x1 is the link register used by calls and returns
`define REG_RA   5'd1

`endif

/* design/fe_ctrl_pkg.sv */
package fe_ctrl_pkg;

	////////////////////
	// widths with a meaning
	////////////////////

	typedef logic [4:0]  reg_addr_t;
	typedef logic [31:0] instr_t;
	typedef logic [31:0] addr_t;

	// bit 1 takes the MEM result of a non-load, bit 0 takes the WB result
	typedef logic [1:0]  fwd_sel_t;

	////////////////////
	// four-phase receiver states
	////////////////////

	typedef enum logic {
		HS_IDLE,
		HS_ACK
	} hs_state_t;

	////////////////////
	// RV32I major opcodes
	////////////////////

	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

endpackage

/* design/instr_predecode.sv */
`timescale 1ns/1ps
`include "riscv_regs.svh"

module instr_predecode (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  req,
	input  fe_ctrl_pkg::instr_t   instr,
	input  fe_ctrl_pkg::addr_t    pc,
	input  logic                  stall_inner,
	output logic                  ack,
	output logic                  accept,
	output fe_ctrl_pkg::reg_addr_t rs1,
	output fe_ctrl_pkg::reg_addr_t rs2,
	output fe_ctrl_pkg::reg_addr_t rd,
	output logic                  reg_write,
	output logic                  mem_read,
	output logic                  jal,
	output logic                  jalr,
	output logic                  b_type,
	output fe_ctrl_pkg::addr_t    link_addr
);
	import fe_ctrl_pkg::*;

	hs_state_t  state;
	hs_state_t  state_next;
	logic       waiting;
	logic [6:0] opcode;
	logic       is_jal, is_jalr, is_branch, is_load, is_store;
	logic       is_op, is_op_imm, is_lui, is_auipc;
	logic       uses_rs1, uses_rs2, has_rd;

	////////////////////
	// four-phase receiver
	////////////////////

	// an instruction waits while req is up and it has not been acknowledged yet
	assign waiting = req && (state == HS_IDLE);
	assign accept  = waiting && !stall_inner;
	assign ack     = (state == HS_ACK);

	always_comb begin
		state_next = state;
		case (state)
			HS_IDLE: if (accept) state_next = HS_ACK;
			HS_ACK:  if (!req) state_next = HS_IDLE;
			default: state_next = HS_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= HS_IDLE;
		end else begin
			state <= state_next;
		end
	end

	////////////////////
	// opcode class and register fields
	////////////////////

	assign opcode    = instr[6:0];
	assign is_jal    = (opcode == OPC_JAL);
	assign is_jalr   = (opcode == OPC_JALR);
	assign is_branch = (opcode == OPC_BRANCH);
	assign is_load   = (opcode == OPC_LOAD);
	assign is_store  = (opcode == OPC_STORE);
	assign is_op     = (opcode == OPC_OP);
	assign is_op_imm = (opcode == OPC_OP_IMM);
	assign is_lui    = (opcode == OPC_LUI);
	assign is_auipc  = (opcode == OPC_AUIPC);

	// formats that do not read a source report x0 so they never see a hazard
	assign uses_rs1 = is_jalr || is_branch || is_load || is_store || is_op || is_op_imm;
	assign uses_rs2 = is_branch || is_store || is_op;
	assign has_rd   = is_jal || is_jalr || is_load || is_op || is_op_imm || is_lui || is_auipc;

	assign rs1 = uses_rs1 ? instr[19:15] : `REG_ZERO;
	assign rs2 = uses_rs2 ? instr[24:20] : `REG_ZERO;
	assign rd  = has_rd ? instr[11:7] : `REG_ZERO;

	// writes to x0 are dropped here, so x0 never forwards
	assign reg_write = has_rd && (rd != `REG_ZERO);
	assign mem_read  = is_load;

	// class hints only describe the instruction that is actually waiting
	assign jal    = waiting && is_jal;
	assign jalr   = waiting && is_jalr;
	assign b_type = waiting && is_branch;

	assign link_addr = pc + 32'd4;

endmodule

/* design/track_stage.sv */
`timescale 1ns/1ps

module track_stage (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   kill,
	input  logic                   valid_in,
	input  fe_ctrl_pkg::reg_addr_t rd_in,
	input  logic                   reg_write_in,
	input  logic                   mem_read_in,
	input  logic                   jal_in,
	input  logic                   jalr_in,
	output logic                   valid,
	output fe_ctrl_pkg::reg_addr_t rd,
	output logic                   reg_write,
	output logic                   mem_read,
	output logic                   jal,
	output logic                   jalr
);

	logic reg_write_q, mem_read_q, jal_q, jalr_q;

	// a killed slot turns into a bubble at the next edge
	always_ff @(posedge clk) begin
		if (reset || kill) begin
			valid <= 1'b0;
		end else begin
			valid <= valid_in;
		end
	end

	always_ff @(posedge clk) begin
		rd          <= rd_in;
		reg_write_q <= reg_write_in;
		mem_read_q  <= mem_read_in;
		jal_q       <= jal_in;
		jalr_q      <= jalr_in;
	end

	// class bits of a bubble read as zero
	assign reg_write = valid && reg_write_q;
	assign mem_read  = valid && mem_read_q;
	assign jal       = valid && jal_q;
	assign jalr      = valid && jalr_q;

endmodule

/* design/mini_control.sv */
`timescale 1ns/1ps
`include "riscv_regs.svh"

module mini_control (
	input  fe_ctrl_pkg::reg_addr_t rs1,
	input  fe_ctrl_pkg::reg_addr_t rs2,
	input  fe_ctrl_pkg::reg_addr_t rd,
	input  logic                   jal,
	input  logic                   jalr,
	input  logic                   b_type,

	input  fe_ctrl_pkg::reg_addr_t rd_id,
	input  fe_ctrl_pkg::reg_addr_t rd_ex,
	input  fe_ctrl_pkg::reg_addr_t rd_mem,
	input  fe_ctrl_pkg::reg_addr_t rd_wb,
	input  logic                   reg_write_id,
	input  logic                   reg_write_ex,
	input  logic                   reg_write_mem,
	input  logic                   reg_write_wb,
	input  logic                   mem_read_ex,
	input  logic                   mem_read_mem,

	input  logic                   jal_id,
	input  logic                   jalr_id,
	input  logic                   jalr_ex,
	input  logic                   flush,
	input  logic                   accept,

	output fe_ctrl_pkg::fwd_sel_t  rs1_fwd,
	output fe_ctrl_pkg::fwd_sel_t  rs2_fwd,
	output logic                   b_pred_en,
	output logic                   jalr_pred_en,
	output logic                   stall_inner,
	output logic                   ras_push,
	output logic                   ras_pop,
	output logic                   ras_rb_pop_id,
	output logic                   ras_rb_push_id,
	output logic                   ras_rb_push_ex
);

	logic rs1_hz_id, rs1_hz_ex, rs1_hz_mem, rs1_hz_wb;
	logic rs2_hz_id, rs2_hz_ex, rs2_hz_mem, rs2_hz_wb;
	logic rs1_hz_ex_noload;
	logic rs1_hz_mem_load, rs1_hz_mem_noload;
	logic rs2_hz_mem_load, rs2_hz_mem_noload;
	logic rd_is_ra, rd_is_ra_id;

	////////////////////
	// raw hazards per stage
	////////////////////

	assign rs1_hz_id  = reg_write_id  && (rd_id  == rs1);
	assign rs1_hz_ex  = reg_write_ex  && (rd_ex  == rs1);
	assign rs1_hz_mem = reg_write_mem && (rd_mem == rs1);
	assign rs1_hz_wb  = reg_write_wb  && (rd_wb  == rs1);

	assign rs2_hz_id  = reg_write_id  && (rd_id  == rs2);
	assign rs2_hz_ex  = reg_write_ex  && (rd_ex  == rs2);
	assign rs2_hz_mem = reg_write_mem && (rd_mem == rs2);
	assign rs2_hz_wb  = reg_write_wb  && (rd_wb  == rs2);

	// a load in MEM has no data yet, anything else in MEM can be forwarded
	assign rs1_hz_ex_noload  = rs1_hz_ex && !mem_read_ex;
	assign rs1_hz_mem_load   = rs1_hz_mem && mem_read_mem;
	assign rs1_hz_mem_noload = rs1_hz_mem && !mem_read_mem;
	assign rs2_hz_mem_load   = rs2_hz_mem && mem_read_mem;
	assign rs2_hz_mem_noload = rs2_hz_mem && !mem_read_mem;

	////////////////////
	// forwarding and prediction hints
	////////////////////

	assign rs1_fwd = {rs1_hz_mem_noload, rs1_hz_wb};
	assign rs2_fwd = {rs2_hz_mem_noload, rs2_hz_wb};

	// a branch whose operands are not ready early is left to the predictor
	assign b_pred_en = b_type && (rs1_hz_id || rs2_hz_id || rs1_hz_ex || rs2_hz_ex ||
		rs1_hz_mem_load || rs2_hz_mem_load);

	assign rd_is_ra    = (rd == `REG_RA);
	assign rd_is_ra_id = (rd_id == `REG_RA);

	assign jalr_pred_en = jalr && !rd_is_ra && (rs1_hz_id || rs1_hz_ex || rs1_hz_mem_load);

	// calls through a register wait until the target can be forwarded
	assign stall_inner = jalr && rd_is_ra && (rs1_hz_ex_noload || rs1_hz_mem_load);

	////////////////////
	// return stack commands
	////////////////////

	assign ras_push = accept && !flush &&  rd_is_ra && (jal || jalr);
	assign ras_pop  = accept && !flush && !rd_is_ra && jalr;

	// undo what the killed ID instruction did to the stack
	assign ras_rb_pop_id  = flush &&  rd_is_ra_id && (jal_id || jalr_id);
	assign ras_rb_push_id = flush && !rd_is_ra_id && jalr_id;
	assign ras_rb_push_ex = flush && jalr_ex;

endmodule

/* design/return_stack.sv */
`timescale 1ns/1ps

module return_stack #(
	parameter int RAS_DEPTH = 8
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               push,
	input  logic               pop,
	input  logic               rb_pop_id,
	input  logic               rb_push_id,
	input  logic               rb_push_ex,
	input  fe_ctrl_pkg::addr_t push_addr,
	output fe_ctrl_pkg::addr_t top
);
	import fe_ctrl_pkg::*;

	localparam int PTR_W = $clog2(RAS_DEPTH);

	addr_t            entries [RAS_DEPTH];
	logic [PTR_W-1:0] ptr;
	logic [PTR_W-1:0] ptr_next;

	////////////////////
	// pointer update
	////////////////////

	// the pointer always names the current top entry
	// and the depth is a power of two, so the sum wraps on its own
	always_comb begin
		ptr_next = ptr
			+ PTR_W'(push)
			+ PTR_W'(rb_push_id)
			+ PTR_W'(rb_push_ex)
			- PTR_W'(pop)
			- PTR_W'(rb_pop_id);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ptr <= '0;
		end else begin
			ptr <= ptr_next;
		end
	end

	////////////////////
	// entry storage
	////////////////////

	// pops leave the entry in place so a rollback push finds the old top again
	always_ff @(posedge clk) begin
		if (push) begin
			entries[ptr_next] <= push_addr;
		end
	end

	assign top = entries[ptr];

endmodule

/* design/fe_ctrl_top.sv */
`timescale 1ns/1ps

module fe_ctrl_top #(
	parameter int RAS_DEPTH = 8
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  req,
	input  fe_ctrl_pkg::instr_t   instr,
	input  fe_ctrl_pkg::addr_t    pc,
	input  logic                  flush,
	output logic                  ack,
	output fe_ctrl_pkg::fwd_sel_t rs1_fwd,
	output fe_ctrl_pkg::fwd_sel_t rs2_fwd,
	output logic                  b_pred_en,
	output logic                  jalr_pred_en,
	output logic                  stall,
	output fe_ctrl_pkg::addr_t    ras_top
);
	import fe_ctrl_pkg::*;

	reg_addr_t  rs1, rs2;
	reg_addr_t  slot_rd [5];
	logic [4:0] slot_valid, slot_wr, slot_mr, slot_jal, slot_jalr;
	logic       accept, b_type, stall_inner;
	addr_t      link_addr;
	logic       ras_push, ras_pop, ras_rb_pop_id, ras_rb_push_id, ras_rb_push_ex;

	assign stall = stall_inner;

	// index 0 is the load side of the ID slot, index k+1 is the output of slot k
	instr_predecode u_predecode (
		.clk(clk), .reset(reset), .req(req), .instr(instr), .pc(pc),
		.stall_inner(stall_inner), .ack(ack), .accept(accept),
		.rs1(rs1), .rs2(rs2), .rd(slot_rd[0]),
		.reg_write(slot_wr[0]), .mem_read(slot_mr[0]),
		.jal(slot_jal[0]), .jalr(slot_jalr[0]), .b_type(b_type),
		.link_addr(link_addr)
	);

	assign slot_valid[0] = accept;

	////////////////////
	// shadow pipeline ID, EX, MEM, WB
	////////////////////

	for (genvar k = 0; k < 4; k++) begin : g_slot
		// a redirect from EX kills the two youngest slots
		track_stage u_slot (
			.clk(clk), .reset(reset), .kill(flush && (k < 2)),
			.valid_in(slot_valid[k]), .rd_in(slot_rd[k]),
			.reg_write_in(slot_wr[k]), .mem_read_in(slot_mr[k]),
			.jal_in(slot_jal[k]), .jalr_in(slot_jalr[k]),
			.valid(slot_valid[k+1]), .rd(slot_rd[k+1]),
			.reg_write(slot_wr[k+1]), .mem_read(slot_mr[k+1]),
			.jal(slot_jal[k+1]), .jalr(slot_jalr[k+1])
		);
	end

	mini_control u_ctrl (
		.rs1(rs1), .rs2(rs2), .rd(slot_rd[0]),
		.jal(slot_jal[0]), .jalr(slot_jalr[0]), .b_type(b_type),
		.rd_id(slot_rd[1]), .rd_ex(slot_rd[2]), .rd_mem(slot_rd[3]), .rd_wb(slot_rd[4]),
		.reg_write_id(slot_wr[1]), .reg_write_ex(slot_wr[2]),
		.reg_write_mem(slot_wr[3]), .reg_write_wb(slot_wr[4]),
		.mem_read_ex(slot_mr[2]), .mem_read_mem(slot_mr[3]),
		.jal_id(slot_jal[1]), .jalr_id(slot_jalr[1]), .jalr_ex(slot_jalr[2]),
		.flush(flush), .accept(accept),
		.rs1_fwd(rs1_fwd), .rs2_fwd(rs2_fwd),
		.b_pred_en(b_pred_en), .jalr_pred_en(jalr_pred_en), .stall_inner(stall_inner),
		.ras_push(ras_push), .ras_pop(ras_pop), .ras_rb_pop_id(ras_rb_pop_id),
		.ras_rb_push_id(ras_rb_push_id), .ras_rb_push_ex(ras_rb_push_ex)
	);

	return_stack #(.RAS_DEPTH(RAS_DEPTH)) u_ras (
		.clk(clk), .reset(reset), .push(ras_push), .pop(ras_pop),
		.rb_pop_id(ras_rb_pop_id), .rb_push_id(ras_rb_push_id),
		.rb_push_ex(ras_rb_push_ex), .push_addr(link_addr), .top(ras_top)
	);

endmodule

/* dv/tb_fe_ctrl.sv */
`timescale 1ns/1ps

module tb_fe_ctrl;
	import fe_ctrl_pkg::*;

	localparam int RAS_DEPTH = 8;
	localparam int MAX_CYCLES = 3000;

	logic clk = 1'b0, reset = 1'b1, req = 1'b0, flush = 1'b0;
	instr_t instr = '0;
	addr_t pc = '0;
	logic ack, b_pred_en, jalr_pred_en, stall;
	fwd_sel_t rs1_fwd, rs2_fwd;
	addr_t ras_top;
	int seed = 32'h9c9b_9484;
	int cycles = 0;

	// the reference model counts index 0 as ID and 3 as WB
	logic m_v[4], m_wr[4], m_mr[4], m_jal[4], m_jalr[4];
	reg_addr_t m_rd[4];
	logic m_ack;
	addr_t m_stk[64];
	logic m_set[64];
	int m_ptr;

	fe_ctrl_top #(.RAS_DEPTH(RAS_DEPTH)) UUT (
		.clk(clk), .reset(reset), .req(req), .instr(instr), .pc(pc), .flush(flush),
		.ack(ack), .rs1_fwd(rs1_fwd), .rs2_fwd(rs2_fwd), .b_pred_en(b_pred_en),
		.jalr_pred_en(jalr_pred_en), .stall(stall), .ras_top(ras_top)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > MAX_CYCLES) begin
			$display("timeout, the DUT did not finish the tests in %0d cycles", MAX_CYCLES);
			$display("*** FAILED ***");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	function automatic void decode(input instr_t i, output reg_addr_t s1, output reg_addr_t s2,
		output reg_addr_t d, output logic wr, output logic mr, output logic jl,
		output logic jr, output logic br);
		logic [6:0] op;
		logic u1, u2, hd;
		op = i[6:0];
		jl = (op == OPC_JAL);
		jr = (op == OPC_JALR);
		br = (op == OPC_BRANCH);
		mr = (op == OPC_LOAD);
		u1 = jr || br || mr || op == OPC_STORE || op == OPC_OP || op == OPC_OP_IMM;
		u2 = br || op == OPC_STORE || op == OPC_OP;
		hd = jl || jr || mr || op == OPC_OP || op == OPC_OP_IMM || op == OPC_LUI
			|| op == OPC_AUIPC;
		s1 = u1 ? i[19:15] : 5'd0;
		s2 = u2 ? i[24:20] : 5'd0;
		d = hd ? i[11:7] : 5'd0;
		wr = hd && (d != 5'd0);
	endfunction

	function automatic logic hz(input int k, input reg_addr_t r);
		return m_v[k] && m_wr[k] && (m_rd[k] == r);
	endfunction

	// expected combinational outputs for the instruction on the inputs now
	task automatic expect_now(output fwd_sel_t f1, output fwd_sel_t f2, output logic b,
		output logic jp, output logic st);
		reg_addr_t s1, s2, d;
		logic wr, mr, jl, jr, br, w;
		decode(instr, s1, s2, d, wr, mr, jl, jr, br);
		w = req && !m_ack;
		f1 = {hz(2, s1) && !m_mr[2], hz(3, s1)};
		f2 = {hz(2, s2) && !m_mr[2], hz(3, s2)};
		b = w && br && (hz(0, s1) || hz(0, s2) || hz(1, s1) || hz(1, s2)
			|| (m_mr[2] && (hz(2, s1) || hz(2, s2))));
		jp = w && jr && d != 5'd1 && (hz(0, s1) || hz(1, s1) || (hz(2, s1) && m_mr[2]));
		st = w && jr && d == 5'd1 && ((hz(1, s1) && !m_mr[1]) || (hz(2, s1) && m_mr[2]));
	endtask

	always @(posedge clk) begin
		reg_addr_t s1, s2, d;
		logic wr, mr, jl, jr, br, acc, b, jp, st, push, pop, rbp, rbi, rbe;
		fwd_sel_t f1, f2;
		int np;
		decode(instr, s1, s2, d, wr, mr, jl, jr, br);
		expect_now(f1, f2, b, jp, st);
		acc = req && !m_ack && !st;
		if (reset) begin
			m_v <= '{default: 1'b0};
			m_ack <= 1'b0;
			m_ptr <= 0;
		end else begin
			for (int k = 3; k > 0; k--) begin
				m_v[k] <= (k == 1 && flush) ? 1'b0 : m_v[k-1];
				m_rd[k] <= m_rd[k-1];
				m_wr[k] <= m_wr[k-1];
				m_mr[k] <= m_mr[k-1];
				m_jal[k] <= m_jal[k-1];
				m_jalr[k] <= m_jalr[k-1];
			end
			m_v[0] <= acc && !flush;
			m_rd[0] <= d;
			m_wr[0] <= wr;
			m_mr[0] <= mr;
			m_jal[0] <= jl;
			m_jalr[0] <= jr;
			if (!m_ack && acc)
				m_ack <= 1'b1;
			else if (m_ack && !req)
				m_ack <= 1'b0;
			push = acc && !flush && d == 5'd1 && (jl || jr);
			pop = acc && !flush && d != 5'd1 && jr;
			rbp = flush && m_v[0] && m_rd[0] == 5'd1 && (m_jal[0] || m_jalr[0]);
			rbi = flush && m_v[0] && m_rd[0] != 5'd1 && m_jalr[0];
			rbe = flush && m_v[1] && m_jalr[1];
			np = (m_ptr + push + rbi + rbe - pop - rbp + RAS_DEPTH) % RAS_DEPTH;
			m_ptr <= np;
			if (push) begin
				m_stk[np] <= pc + 32'd4;
				m_set[np] <= 1'b1;
			end
		end
	end

	task automatic check_fwd(input string name, input fwd_sel_t exp, input fwd_sel_t act);
		if (exp !== act) begin
			$display("mismatch %s expected %0b actual %0b", name, exp, act);
			$display("*** FAILED ***");
			$fatal(1, "forwarding select differs");
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("mismatch %s expected %0b actual %0b", name, exp, act);
			$display("*** FAILED ***");
			$fatal(1, "control bit differs");
		end
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (exp !== act) begin
			$display("mismatch %s expected %08h actual %08h", name, exp, act);
			$display("*** FAILED ***");
			$fatal(1, "return target differs");
		end
	endtask

	task automatic check_all(input string name);
		fwd_sel_t f1, f2;
		logic b, jp, st;
		expect_now(f1, f2, b, jp, st);
		check_bit({name, " ack"}, m_ack, ack);
		if (req && !ack) begin
			check_fwd({name, " rs1_fwd"}, f1, rs1_fwd);
			check_fwd({name, " rs2_fwd"}, f2, rs2_fwd);
			check_bit({name, " b_pred_en"}, b, b_pred_en);
			check_bit({name, " jalr_pred_en"}, jp, jalr_pred_en);
			check_bit({name, " stall"}, st, stall);
		end
		if (m_set[m_ptr])
			check_addr({name, " ras_top"}, m_stk[m_ptr], ras_top);
	endtask

	// fl of 1 pulses flush while the instruction sits in ID and fl of 2 while it sits in EX
	task automatic send(input string name, input instr_t i, input addr_t p, input int fl);
		fwd_sel_t f1, f2;
		logic b, jp, st, will_acc;
		@(posedge clk);
		req <= 1'b1;
		instr <= i;
		pc <= p;
		forever begin
			@(negedge clk);
			check_all(name);
			if (ack)
				break;
			expect_now(f1, f2, b, jp, st);
			will_acc = !m_ack && !st;
			@(posedge clk);
			if (fl == 1 && will_acc)
				flush <= 1'b1;
		end
		@(posedge clk);
		req <= 1'b0;
		flush <= (fl == 2);
		if (fl == 2) begin
			@(posedge clk);
			flush <= 1'b0;
		end
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clk);
	endtask

	function automatic reg_addr_t rnd_reg();
		return reg_addr_t'(2 + ($unsigned($random(seed)) % 30));
	endfunction

	function automatic addr_t rnd_pc();
		return addr_t'($random(seed)) & 32'hffff_fffc;
	endfunction

	function automatic instr_t op_r(input logic [6:0] opc, input reg_addr_t d,
		input reg_addr_t s1, input reg_addr_t s2);
		return {7'b0, s2, s1, 3'b0, d, opc};
	endfunction

	////////////////////
	// directed tests
	////////////////////

	task automatic test_forwarding();
		reg_addr_t r;
		for (int gap = 0; gap < 3; gap++) begin
			r = rnd_reg();
			send("fwd producer", op_r(OPC_OP, r, rnd_reg(), rnd_reg()), rnd_pc(), 0);
			idle(gap);
			send("fwd consumer", op_r(OPC_OP, rnd_reg(), r, r), rnd_pc(), 0);
		end
		// x0 as destination is never a producer
		send("fwd x0 producer", op_r(OPC_OP, 5'd0, 5'd3, 5'd4), rnd_pc(), 0);
		send("fwd x0 consumer", op_r(OPC_OP, 5'd5, 5'd0, 5'd0), rnd_pc(), 0);
	endtask

	task automatic test_branch();
		reg_addr_t r;
		r = rnd_reg();
		send("br alu producer", op_r(OPC_OP, r, 5'd2, 5'd3), rnd_pc(), 0);
		send("br after alu", op_r(OPC_BRANCH, 5'd0, r, 5'd7), rnd_pc(), 0);
		send("br load producer", op_r(OPC_LOAD, r, 5'd2, 5'd0), rnd_pc(), 0);
		send("br after load", op_r(OPC_BRANCH, 5'd0, 5'd7, r), rnd_pc(), 0);
		idle(3);
		send("br no hazard", op_r(OPC_BRANCH, 5'd0, r, r), rnd_pc(), 0);
	endtask

	task automatic test_stall();
		reg_addr_t r;
		r = rnd_reg();
		send("stall load", op_r(OPC_LOAD, r, 5'd2, 5'd0), rnd_pc(), 0);
		send("stall call", op_r(OPC_JALR, 5'd1, r, 5'd0), rnd_pc(), 0);
		send("jalr load", op_r(OPC_LOAD, r, 5'd2, 5'd0), rnd_pc(), 0);
		send("jalr hint", op_r(OPC_JALR, 5'd6, r, 5'd0), rnd_pc(), 0);
	endtask

	task automatic test_return_stack();
		for (int k = 0; k < RAS_DEPTH + 3; k++) begin
			if (k % 2 == 0)
				send("ras jal call", op_r(OPC_JAL, 5'd1, 5'd0, 5'd0), rnd_pc(), 0);
			else
				send("ras jalr call", op_r(OPC_JALR, 5'd1, rnd_reg(), 5'd0), rnd_pc(), 0);
		end
		for (int k = 0; k < RAS_DEPTH + 3; k++)
			send("ras return", op_r(OPC_JALR, 5'd0, 5'd1, 5'd0), rnd_pc(), 0);
	endtask

	task automatic test_flush();
		reg_addr_t r;
		send("flush seed call", op_r(OPC_JAL, 5'd1, 5'd0, 5'd0), rnd_pc(), 0);
		send("flush call in id", op_r(OPC_JAL, 5'd1, 5'd0, 5'd0), rnd_pc(), 1);
		send("flush return in id", op_r(OPC_JALR, 5'd0, 5'd1, 5'd0), rnd_pc(), 1);
		send("flush return in ex", op_r(OPC_JALR, 5'd0, 5'd1, 5'd0), rnd_pc(), 2);
		r = rnd_reg();
		send("flush killed producer", op_r(OPC_OP, r, 5'd2, 5'd3), rnd_pc(), 1);
		send("flush consumer", op_r(OPC_OP, 5'd9, r, r), rnd_pc(), 0);
	endtask

	initial begin
		m_set = '{default: 1'b0};
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		test_forwarding();
		test_branch();
		test_stall();
		test_return_stack();
		test_flush();
		idle(4);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+include
design/fe_ctrl_pkg.sv
design/instr_predecode.sv
design/track_stage.sv
design/mini_control.sv
design/return_stack.sv
design/fe_ctrl_top.sv
dv/tb_fe_ctrl.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wall -Wno-fatal \
	-f filelist.f \
	--top-module tb_fe_ctrl \
	-Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit $status
fi

./obj_dir/Vtb_fe_ctrl
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0
